// ==== compile.f ====
verilog/rvPkg.sv
verilog/regFile.sv
verilog/immGen.sv
verilog/alu.sv
verilog/datapath.sv
verilog/mainControl.sv
verilog/apbRequester.sv
verilog/cpu.sv
bench/cpuSva.sv
bench/cpuTb.sv

// ==== Makefile ====
# Verilator build for the multicycle CPU

VERILATOR ?= verilator
TOP       ?= cpuTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(SIM) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cpuTb.sv ====
// CPU testbench with ISA model
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import rvPkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int RUNS      = 4;
    localparam int RUN_LIMIT = 40000;   // Cycles per program

    logic        clk;
    logic        rst;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    logic [31:0] prog [MEM_WORDS];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] modelMem [MEM_WORDS];
    logic [31:0] haltPc;
    logic [31:0] seed;
    int          waitLeft;
    bit          zeroWait;

    // Expected APB transfers in order
    bit          traceWr [$];
    logic [31:0] traceAddr [$];
    logic [31:0] traceData [$];

    cpu i_dut (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic reportError(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic int pick(input int n);
        pick = ($random(seed) & 32'h7fffffff) % n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        rType = {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        iType = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        sType = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        bType = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
        jType = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic genProgram();
        int          p;
        int          f3;
        int          alt;
        int          rs1;
        logic [11:0] imm;
        logic [2:0]  brF3 [6];
        brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = {i[15:0], ~i[15:0]} ^ 32'h3c5a_96e1;     // Whole-address fill
        end
        p = 0;
        for (int r = 1; r < 32; r++) begin
            prog[p] = {$random(seed) & 32'hffff_f000} | {20'd0, 5'(r), OP_LUI};
            prog[p + 1] = iType(12'($random(seed)), 5'(r), 3'b000, 5'(r), OP_IMM);
            p += 2;
        end
        for (int k = 0; k < 48; k++) begin
            f3  = pick(8);
            alt = (f3 == 0 || f3 == 5) ? pick(2) : 0;
            rs1 = pick(32);
            case (pick(6))
                0: prog[p] = rType({1'b0, 1'(alt), 5'd0}, 5'(pick(32)), 5'(rs1),
                                   3'(f3), 5'(pick(32)));
                1: begin
                    imm = 12'($random(seed));
                    if (f3 == 1) imm = {7'd0, imm[4:0]};
                    if (f3 == 5) imm = {1'b0, 1'(alt), 5'd0, imm[4:0]};
                    prog[p] = iType(imm, 5'(rs1), 3'(f3), 5'(pick(32)), OP_IMM);
                end
                2: prog[p] = bType(pick(2) ? 13'd8 : 13'd12,
                                   pick(2) ? 5'(rs1) : 5'(pick(32)), 5'(rs1), brF3[pick(6)]);
                3: prog[p] = jType(21'd8, 5'(pick(32)));
                4: prog[p] = sType(12'(32'h400 + 4 * pick(32)), 5'(pick(32)), 5'd0);
                default: prog[p] = iType(12'(32'h400 + 4 * pick(32)), 5'd0, 3'b010,
                                         5'(pick(32)), OP_LOAD);
            endcase
            p++;
        end
        for (int r = 0; r < 32; r++) begin
            prog[p] = sType(12'(32'h600 + 4 * r), 5'(r), 5'd0);   // Register dump
            p++;
        end
        prog[p] = jType(21'd0, 5'd0);
        haltPc  = 32'(p * 4);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ISA reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input bit alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: aluModel = alt ? a - b : a + b;
            3'd1: aluModel = a << b[4:0];
            3'd2: aluModel = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: aluModel = (a < b) ? 32'd1 : 32'd0;
            3'd4: aluModel = a ^ b;
            3'd5: aluModel = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: aluModel = a | b;
            default: aluModel = a & b;
        endcase
    endfunction

    task automatic pushTrace(input bit wr, input logic [31:0] addr, input logic [31:0] data);
        traceWr.push_back(wr);
        traceAddr.push_back(addr);
        traceData.push_back(data);
    endtask

    task automatic modelRun();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [2:0]  f3;
        bit          wr;
        bit          taken;
        int          steps;
        for (int r = 0; r < 32; r++) x[r] = 32'd0;
        pc    = 32'd0;
        steps = 0;
        forever begin
            pushTrace(1'b0, pc, 32'd0);
            if (pc == haltPc || steps > 5000) break;
            ins    = modelMem[pc[11:2]];
            f3     = ins[14:12];
            a      = x[ins[19:15]];
            b      = x[ins[24:20]];
            nextPc = pc + 4;
            wr     = 1'b1;
            res    = 32'd0;
            case (ins[6:0])
                OP_LUI: res = {ins[31:12], 12'd0};
                OP_REG: res = aluModel(f3, ins[30], a, b);
                OP_IMM: res = aluModel(f3, f3 == 3'd5 && ins[30], a,
                                       {{20{ins[31]}}, ins[31:20]});
                OP_JAL: begin
                    res    = pc + 4;
                    nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OP_BRANCH: begin
                    wr = 1'b0;
                    case (f3)
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        3'b110:  taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    if (taken) nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                OP_LOAD: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    pushTrace(1'b0, addr, 32'd0);
                    res = modelMem[addr[11:2]];
                end
                default: begin                          // Store
                    wr   = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    pushTrace(1'b1, addr, b);
                    modelMem[addr[11:2]] = b;
                end
            endcase
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
            pc = nextPc;
            steps++;
        end
        pushTrace(1'b0, haltPc, 32'd0);                 // Self-jump fetched again
    endtask

    task automatic checkTransfer();
        bit          expWr;
        logic [31:0] expAddr;
        logic [31:0] expData;
        assert (traceWr.size() > 0)
            else reportError("APB transfer seen after the program had finished");
        expWr   = traceWr.pop_front();
        expAddr = traceAddr.pop_front();
        expData = traceData.pop_front();
        assert (pwrite === expWr)
            else reportError($sformatf("error pwrite: got %h, expected %h", pwrite, expWr));
        assert (paddr === expAddr)
            else reportError($sformatf("error paddr: got %h, expected %h", paddr, expAddr));
        if (expWr) begin
            assert (pwdata === expData)
                else reportError($sformatf("error pwdata: got %h, expected %h",
                                           pwdata, expData));
        end
    endtask

    // APB memory with random wait states
    always @(posedge clk) begin
        if (!rst && psel && penable && pready) begin
            checkTransfer();
            if (pwrite) mem[paddr[11:2]] = pwdata;
            #1 pready = 1'b0;
        end else if (!rst && psel && !penable) begin
            waitLeft = zeroWait ? 0 : ($random(seed) & 3);
            #1;
            prdata = mem[paddr[11:2]];
            pready = (waitLeft == 0);
        end else if (!rst && psel && penable) begin
            waitLeft--;
            #1 pready = (waitLeft == 0);
        end
    end

    task automatic applyReset();
        @(posedge clk);
        #1 rst = 1'b1;
        pready = 1'b0;
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            if (c > 1) begin
                assert (!psel && !penable && !pwrite)
                    else reportError("APB outputs active during reset");
            end
        end
        #1 rst = 1'b0;
    endtask

    task automatic waitProgramEnd();
        int cycles;
        cycles = 0;
        while (traceWr.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                reportError("timeout waiting for the program to reach its self-jump");
            end
        end
    endtask

    initial begin
        seed     = 32'ha7973d38;
        rst      = 1'b1;
        pready   = 1'b0;
        prdata   = 32'd0;
        zeroWait = 1'b0;
        waitLeft = 0;
        // Last pass replays the previous program with no wait states
        for (int run = 0; run <= RUNS; run++) begin
            if (run < RUNS) genProgram();
            zeroWait = (run == RUNS);
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i]      = prog[i];
                modelMem[i] = prog[i];
            end
            traceWr.delete();
            traceAddr.delete();
            traceData.delete();
            modelRun();
            applyReset();
            waitProgramEnd();
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cpuSva.sv ====
// APB protocol assertions
`timescale 1ns/1ps
`default_nettype none

module cpuSva (
    input logic        clk,
    input logic        rst,
    input logic [31:0] paddr,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [31:0] pwdata,
    input logic        pready
);
    // ACCESS only ever follows one SETUP cycle
    enableAfterSetup: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel && !penable))
        else $error("penable rose without a preceding SETUP cycle");

    holdDuringWait: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pready) |=>
            ($stable(paddr) && $stable(pwrite) && $stable(pwdata) && penable))
        else $error("APB request changed while the transfer was stalled");

    selUntilDone: assert property (@(posedge clk) disable iff (rst)
        (psel && !(penable && pready)) |=> psel)
        else $error("psel dropped before the transfer completed");

endmodule

bind cpu cpuSva u_cpuSva (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pready  (pready)
);

`default_nettype wire

// ==== verilog/cpu.sv ====
// RV32I subset CPU top
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] paddr,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    output logic [31:0] pwdata,
    input  logic [31:0] prdata,
    input  logic        pready
);
    import rvPkg::*;

    instrWord_u  instr;
    logic        eq, lt, ltu;
    logic        memReq, memWrite, memDone;
    logic [31:0] memAddr, memWdata, memRdata;
    logic        pcWrite, irWrite, mdrWrite, operandWrite, aluOutWrite, regWrite;
    logic [1:0]  srcASel, srcBSel;
    logic [3:0]  aluOp;
    logic        addrSel, pcSel, wbSel;

    mainControl u_mainControl (
        .clk(clk), .rst(rst), .instr(instr),
        .eq(eq), .lt(lt), .ltu(ltu), .memDone(memDone),
        .memReq(memReq), .memWrite(memWrite),
        .pcWrite(pcWrite), .irWrite(irWrite), .mdrWrite(mdrWrite),
        .operandWrite(operandWrite), .aluOutWrite(aluOutWrite), .regWrite(regWrite),
        .srcASel(srcASel), .srcBSel(srcBSel), .aluOp(aluOp),
        .addrSel(addrSel), .pcSel(pcSel), .wbSel(wbSel)
    );

    datapath u_datapath (
        .clk(clk), .rst(rst),
        .pcWrite(pcWrite), .irWrite(irWrite), .mdrWrite(mdrWrite),
        .operandWrite(operandWrite), .aluOutWrite(aluOutWrite), .regWrite(regWrite),
        .srcASel(srcASel), .srcBSel(srcBSel), .pcSel(pcSel),
        .wbSel(wbSel), .addrSel(addrSel), .aluOp(aluOp),
        .memRdata(memRdata), .memAddr(memAddr), .memWdata(memWdata),
        .instr(instr), .eq(eq), .lt(lt), .ltu(ltu)
    );

    apbRequester u_apbRequester (
        .clk(clk), .rst(rst),
        .memReq(memReq), .memWrite(memWrite),
        .memAddr(memAddr), .memWdata(memWdata),
        .memDone(memDone), .memRdata(memRdata),
        .paddr(paddr), .pwdata(pwdata),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .prdata(prdata), .pready(pready)
    );

endmodule

`default_nettype wire

// ==== verilog/apbRequester.sv ====
// APB requester
`timescale 1ns/1ps
`default_nettype none

module apbRequester (
    input  logic        clk,
    input  logic        rst,
    input  logic        memReq,
    input  logic        memWrite,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWdata,
    output logic        memDone,
    output logic [31:0] memRdata,
    output logic [31:0] paddr,
    output logic [31:0] pwdata,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    input  logic [31:0] prdata,
    input  logic        pready
);
    import rvPkg::*;

    logic [1:0] state;
    logic       accept;
    logic       finish;

    assign accept = (state == APB_IDLE) && memReq;
    assign finish = (state == APB_ACCESS) && pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= APB_IDLE;
            pwrite  <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= finish;
            case (state)
                APB_IDLE: begin
                    if (memReq) begin
                        state  <= APB_SETUP;
                        pwrite <= memWrite;
                    end
                end
                APB_SETUP: state <= APB_ACCESS;
                default: begin
                    if (pready) state <= APB_IDLE;  // Wait states hold ACCESS
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            paddr  <= memAddr;
            pwdata <= memWdata;
        end
        if (finish) memRdata <= prdata;
    end

    assign psel    = (state != APB_IDLE);
    assign penable = (state == APB_ACCESS);

endmodule

`default_nettype wire

// ==== verilog/mainControl.sv ====
// Multicycle control FSM
`timescale 1ns/1ps
`default_nettype none

module mainControl (
    input  logic              clk,
    input  logic              rst,
    input  rvPkg::instrWord_u instr,
    input  logic              eq,
    input  logic              lt,
    input  logic              ltu,
    input  logic              memDone,
    output logic              memReq,
    output logic              memWrite,
    output logic              pcWrite,
    output logic              irWrite,
    output logic              mdrWrite,
    output logic              operandWrite,
    output logic              aluOutWrite,
    output logic              regWrite,
    output logic [1:0]        srcASel,
    output logic [1:0]        srcBSel,
    output logic [3:0]        aluOp,
    output logic              addrSel,
    output logic              pcSel,
    output logic              wbSel
);
    import rvPkg::*;

    logic [2:0] state;
    logic [2:0] nextState;
    logic       started;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [3:0] arithOp;
    logic       taken;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;

    // Bit 30 picks sub only for OP, sra for both
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (opcode == OP_REG && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arithOp = ALU_SLL;
            3'b010:  arithOp = ALU_SLT;
            3'b011:  arithOp = ALU_SLTU;
            3'b100:  arithOp = ALU_XOR;
            3'b101:  arithOp = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arithOp = ALU_OR;
            default: arithOp = ALU_AND;
        endcase
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State register and memory request pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_FETCH;
            started <= 1'b0;
            memReq  <= 1'b0;
        end else begin
            state   <= nextState;
            started <= 1'b1;
            // One pulse on entry to FETCH or MEM, plus the first fetch
            memReq  <= (nextState == ST_FETCH || nextState == ST_MEM) &&
                       (nextState != state || !started);
        end
    end

    assign memWrite = (state == ST_MEM) && (opcode == OP_STORE);
    assign addrSel  = (state == ST_MEM);

    always_comb begin
        nextState    = state;
        pcWrite      = 1'b0;
        irWrite      = 1'b0;
        mdrWrite     = 1'b0;
        operandWrite = 1'b0;
        aluOutWrite  = 1'b0;
        regWrite     = 1'b0;
        srcASel      = SRCA_PC;
        srcBSel      = SRCB_FOUR;
        aluOp        = ALU_ADD;
        pcSel        = 1'b1;
        wbSel        = 1'b0;
        case (state)
            ST_FETCH: begin
                aluOutWrite = 1'b1;                     // ALUOut <= PC+4
                irWrite     = memDone;
                if (memDone) nextState = ST_DECODE;
            end
            ST_DECODE: begin
                operandWrite = 1'b1;
                srcBSel      = SRCB_IMM;                // PC + imm
                pcWrite      = 1'b1;
                if (opcode == OP_JAL) begin
                    pcSel = 1'b0;                       // Target straight to PC, link stays in ALUOut
                end else begin
                    aluOutWrite = 1'b1;
                end
                case (opcode)
                    OP_REG, OP_IMM, OP_LUI: nextState = ST_EXEC;
                    OP_JAL:                 nextState = ST_JUMP;
                    OP_BRANCH:              nextState = ST_BRANCH;
                    OP_LOAD, OP_STORE:      nextState = ST_ADDR;
                    default:                nextState = ST_FETCH;
                endcase
            end
            ST_EXEC: begin
                srcASel     = (opcode == OP_LUI) ? SRCA_ZERO : SRCA_RS1;
                srcBSel     = (opcode == OP_REG) ? SRCB_RS2 : SRCB_IMM;
                aluOp       = (opcode == OP_LUI) ? ALU_ADD : arithOp;
                aluOutWrite = 1'b1;
                nextState   = ST_WRITEBACK;
            end
            ST_WRITEBACK: begin
                regWrite  = 1'b1;
                wbSel     = (opcode == OP_LOAD);
                nextState = ST_FETCH;
            end
            ST_JUMP: begin
                regWrite  = 1'b1;
                nextState = ST_FETCH;
            end
            ST_BRANCH: begin
                srcASel   = SRCA_RS1;
                srcBSel   = SRCB_RS2;
                pcWrite   = taken;                      // ALUOut holds the target
                nextState = ST_FETCH;
            end
            ST_ADDR: begin
                srcASel     = SRCA_RS1;
                srcBSel     = SRCB_IMM;
                aluOutWrite = 1'b1;
                nextState   = ST_MEM;
            end
            default: begin                              // ST_MEM
                mdrWrite = memDone;
                if (memDone) nextState = (opcode == OP_LOAD) ? ST_WRITEBACK : ST_FETCH;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/datapath.sv ====
// Multicycle datapath
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic              clk,
    input  logic              rst,
    input  logic              pcWrite,
    input  logic              irWrite,
    input  logic              mdrWrite,
    input  logic              operandWrite,
    input  logic              aluOutWrite,
    input  logic              regWrite,
    input  logic [1:0]        srcASel,
    input  logic [1:0]        srcBSel,
    input  logic              pcSel,        // 0 ALU result, 1 ALUOut
    input  logic              wbSel,        // 0 ALUOut, 1 MDR
    input  logic              addrSel,      // 0 PC, 1 ALUOut
    input  logic [3:0]        aluOp,
    input  logic [31:0]       memRdata,
    output logic [31:0]       memAddr,
    output logic [31:0]       memWdata,
    output rvPkg::instrWord_u instr,
    output logic              eq,
    output logic              lt,
    output logic              ltu
);
    import rvPkg::*;

    logic [31:0] pc;
    instrWord_u  ir;
    logic [31:0] mdr;
    logic [31:0] rs1Reg;
    logic [31:0] rs2Reg;
    logic [31:0] aluOut;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] imm;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic [31:0] wbData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Architectural and intermediate registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= 32'd0;
        end else if (pcWrite) begin
            pc <= pcSel ? aluOut : aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) ir <= memRdata;
        if (mdrWrite) mdr <= memRdata;
        if (aluOutWrite) aluOut <= aluResult;
        if (operandWrite) begin
            rs1Reg <= rs1Data;
            rs2Reg <= rs2Data;
        end
    end

    // Operand and address muxes
    always_comb begin
        case (srcASel)
            SRCA_PC:  srcA = pc;
            SRCA_RS1: srcA = rs1Reg;
            default:  srcA = 32'd0;     // LUI adds to zero
        endcase
        case (srcBSel)
            SRCB_RS2:  srcB = rs2Reg;
            SRCB_FOUR: srcB = 32'd4;
            default:   srcB = imm;
        endcase
    end

    assign wbData   = wbSel ? mdr : aluOut;
    assign memAddr  = addrSel ? aluOut : pc;
    assign memWdata = rs2Reg;
    assign instr    = ir;

    regFile u_regFile (
        .clk      (clk),
        .rst      (rst),
        .regWrite (regWrite),
        .rs1Addr  (ir.r.rs1),
        .rs2Addr  (ir.r.rs2),
        .rdAddr   (ir.r.rd),
        .rdData   (wbData),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data)
    );

    immGen u_immGen (
        .instr (ir),
        .imm   (imm)
    );

    alu u_alu (
        .a      (srcA),
        .b      (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .eq     (eq),
        .lt     (lt),
        .ltu    (ltu)
    );

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
// Integer ALU with compare flags
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [3:0]  aluOp,
    output logic [31:0] result,
    output logic        eq,
    output logic        lt,
    output logic        ltu
);
    import rvPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Flags feed the branch decision too
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'd0, lt};
            ALU_SLTU: result = {31'd0, ltu};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/immGen.sv ====
// Immediate decoder
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvPkg::instrWord_u instr,
    output logic [31:0]       imm
);
    import rvPkg::*;

    always_comb begin
        case (instr.r.opcode)
            OP_IMM, OP_LOAD: begin
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            OP_STORE: begin
                imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            OP_BRANCH: begin
                imm = {{20{instr.b.immSign}}, instr.b.imm11, instr.b.immHi,
                       instr.b.immLo, 1'b0};
            end
            OP_LUI: begin
                imm = {instr.u.imm, 12'd0};
            end
            OP_JAL: begin
                imm = {{12{instr.j.immSign}}, instr.j.immHi, instr.j.imm11,
                       instr.j.immLo, 1'b0};
            end
            default: begin
                imm = 32'd0;    // R-type has none
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        regWrite,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic [31:0] rdData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);
    logic [31:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (regWrite && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? 32'd0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? 32'd0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== verilog/rvPkg.sv ====
// RV32I subset definitions
`default_nettype none

package rvPkg;

    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLL  = 4'd2;
    localparam logic [3:0] ALU_SLT  = 4'd3;
    localparam logic [3:0] ALU_SLTU = 4'd4;
    localparam logic [3:0] ALU_XOR  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_OR   = 4'd8;
    localparam logic [3:0] ALU_AND  = 4'd9;

    localparam logic [1:0] SRCA_PC   = 2'd0;
    localparam logic [1:0] SRCA_RS1  = 2'd1;
    localparam logic [1:0] SRCA_ZERO = 2'd2;

    localparam logic [1:0] SRCB_RS2  = 2'd0;
    localparam logic [1:0] SRCB_FOUR = 2'd1;
    localparam logic [1:0] SRCB_IMM  = 2'd2;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Control FSM states
    localparam logic [2:0] ST_FETCH     = 3'd0;
    localparam logic [2:0] ST_DECODE    = 3'd1;
    localparam logic [2:0] ST_EXEC      = 3'd2;
    localparam logic [2:0] ST_WRITEBACK = 3'd3;
    localparam logic [2:0] ST_JUMP      = 3'd4;
    localparam logic [2:0] ST_BRANCH    = 3'd5;
    localparam logic [2:0] ST_ADDR      = 3'd6;
    localparam logic [2:0] ST_MEM       = 3'd7;

    // APB requester states
    localparam logic [1:0] APB_IDLE   = 2'd0;
    localparam logic [1:0] APB_SETUP  = 2'd1;
    localparam logic [1:0] APB_ACCESS = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One instruction word, six field layouts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       immSign;    // imm[12]
            logic [5:0] immHi;      // imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] immLo;      // imm[4:1]
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       immSign;    // imm[20]
            logic [9:0] immLo;      // imm[10:1]
            logic       imm11;
            logic [7:0] immHi;      // imm[19:12]
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instrWord_u;

endpackage

`default_nettype wire
